/* project.f */
logic/hci_pkg.sv
logic/hci_queue.sv
logic/hci_apb_regs.sv
logic/hci_top.sv
testbench/hci_checker.sv
testbench/tb_hci.sv

/* Bender.yml */
package:
  name: i3c_hci_queues

sources:
  - logic/hci_pkg.sv
  - logic/hci_queue.sv
  - logic/hci_apb_regs.sv
  - logic/hci_top.sv
  - target: test
    files:
      - testbench/hci_checker.sv
      - testbench/tb_hci.sv

/* testbench/tb_hci.sv */
// ----------------------------------------------------------
// HCI queue testbench: random APB and controller traffic
// checked against a model of both queues
// ----------------------------------------------------------
module tb_hci
  import hci_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CmdDepth      = 8;
  localparam int RespDepth     = 8;
  localparam int NumCmdOps     = 300;
  localparam int NumRespOps    = 200;
  localparam int NumThldOps    = 50;
  localparam int NumFlushOps   = 20;
  localparam int NumOps        = NumCmdOps + NumRespOps + NumThldOps + NumFlushOps;
  localparam int TimeoutCycles = 40 * NumOps + 200;

  logic      clk_i, rst_ni;
  logic      psel_i, penable_i, pwrite_i;
  apb_addr_t paddr_i;
  apb_data_t pwdata_i, prdata_o;
  logic      pready_o, pslverr_o;
  logic      cmd_rvalid_o, cmd_rready_i;
  cmd_t      cmd_rdata_o;
  logic      resp_wvalid_i, resp_wready_o;
  resp_t     resp_wdata_i;
  logic      cmd_thld_trig_o, resp_thld_trig_o;

  // Model state
  cmd_t      cmd_model[$];
  resp_t     resp_model[$];
  thld_t     cmd_thld = 8'd1;
  thld_t     resp_thld = 8'd1;
  bit        half_model = 1'b0;
  apb_data_t cmd_lo_model;
  bit        cmd_pop_pend = 1'b0, cmd_push_pend = 1'b0;
  bit        resp_pop_pend = 1'b0, resp_push_pend = 1'b0;
  cmd_t      cmd_push_data;
  resp_t     resp_push_data;

  // Controller stimulus
  int        seed = 44685;
  int        cycles = 0;
  int        ctrl_rnd;
  bit        cmd_pop_en = 1'b0, resp_push_en = 1'b0;
  int        pop_mask = 1, push_mask = 1;
  logic      rready_nxt = 1'b0, wvalid_nxt = 1'b0;
  resp_t     wdata_nxt = '0;

  hci_top #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) i_hci_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  function automatic int clip_thld(input thld_t t, input int depth);
    return (int'(t) > depth) ? depth : int'(t);
  endfunction

  function automatic logic cmd_trig_exp();
    int lim;
    lim = (clip_thld(cmd_thld, CmdDepth) == 0) ? 1 : clip_thld(cmd_thld, CmdDepth);
    return (CmdDepth - cmd_model.size()) >= lim;  // Free slots
  endfunction

  function automatic logic resp_trig_exp();
    int lim;
    lim = (clip_thld(resp_thld, RespDepth) == 0) ? 1 : clip_thld(resp_thld, RespDepth);
    return resp_model.size() >= lim;
  endfunction

  function automatic logic is_mapped(input apb_addr_t addr);
    return addr == RegResetCtrl || addr == RegThldCtrl || addr == RegCmdPort
        || addr == RegRespPort || addr == RegQueueStatus;
  endfunction

  function automatic apb_data_t read_exp(input apb_addr_t addr);
    apb_data_t v;
    v = '0;
    case (addr)
      RegThldCtrl: begin
        v[7:0]  = 8'(clip_thld(cmd_thld, CmdDepth));
        v[15:8] = 8'(clip_thld(resp_thld, RespDepth));
      end
      RegRespPort: if (resp_model.size() != 0) v = resp_model[0];
      RegQueueStatus: begin
        v[7:0]  = 8'(cmd_model.size());
        v[15:8] = 8'(resp_model.size());
        v[16]   = cmd_trig_exp();
        v[17]   = resp_trig_exp();
      end
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    logic exp_err;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    exp_err = !is_mapped(addr);
    if (addr == RegCmdPort) begin
      if (!half_model) begin
        cmd_lo_model = data;
      end else if (cmd_model.size() == CmdDepth) begin
        exp_err = 1'b1;  // Full queue drops the command
      end else begin
        cmd_push_pend = 1'b1;
        cmd_push_data = {data, cmd_lo_model};
      end
      half_model = !half_model;
    end
    check_val("pready_o", pready_o, 1'b1);
    check_val("pslverr_o", pslverr_o, exp_err);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    if (addr == RegThldCtrl) begin
      cmd_thld  = data[7:0];
      resp_thld = data[15:8];
    end
  endtask

  task automatic apb_read(input apb_addr_t addr);
    logic exp_err;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    exp_err = !is_mapped(addr) || (addr == RegRespPort && resp_model.size() == 0);
    check_val("pready_o", pready_o, 1'b1);
    check_val("prdata_o", prdata_o, read_exp(addr));
    check_val("pslverr_o", pslverr_o, exp_err);
    if (addr == RegRespPort && resp_model.size() != 0) begin
      resp_pop_pend = 1'b1;
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic flush_one();
    int which;
    cmd_pop_en   = 1'b1;
    resp_push_en = 1'b1;
    pop_mask     = 3;
    push_mask    = 1;
    repeat (2) begin
      apb_write(RegCmdPort, $random(seed));
      apb_write(RegCmdPort, $random(seed));
    end
    apb_read(RegRespPort);
    cmd_pop_en   = 1'b0;  // Controller goes quiet
    resp_push_en = 1'b0;
    repeat (2) @(posedge clk_i);
    apb_read(RegQueueStatus);
    which = $random(seed) & 1;
    apb_write(RegResetCtrl, apb_data_t'(1) << which);
    @(posedge clk_i);  // Queue empties here
    if (which == 0) begin
      cmd_model.delete();
    end else begin
      resp_model.delete();
    end
    @(posedge clk_i);
    apb_read(RegResetCtrl);
    apb_read(RegQueueStatus);
  endtask

  // Sample controller handshakes where they are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_val("cmd_thld_trig_o", cmd_thld_trig_o, cmd_trig_exp());
      check_val("resp_thld_trig_o", resp_thld_trig_o, resp_trig_exp());
      check_val("cmd_rvalid_o", cmd_rvalid_o, cmd_model.size() != 0);
      check_val("resp_wready_o", resp_wready_o, resp_model.size() != RespDepth);
      if (cmd_rvalid_o && cmd_rready_i) begin
        check_val("cmd_rdata_o", cmd_rdata_o, cmd_model[0]);
        cmd_pop_pend = 1'b1;
      end
      if (resp_wvalid_i && resp_wready_o) begin
        resp_push_pend = 1'b1;
        resp_push_data = resp_wdata_i;
      end
      ctrl_rnd   = $random(seed);
      rready_nxt = cmd_pop_en && ((ctrl_rnd & pop_mask) == 0);
      if (!(resp_push_en && resp_wvalid_i && !resp_wready_o)) begin
        ctrl_rnd   = $random(seed);
        wvalid_nxt = resp_push_en && ((ctrl_rnd & push_mask) == 0);
        wdata_nxt  = $random(seed);
      end
    end
  end

  // Model follows the DUT edge
  always @(posedge clk_i) begin
    if (cmd_pop_pend) begin
      void'(cmd_model.pop_front());
      cmd_pop_pend = 1'b0;
    end
    if (cmd_push_pend) begin
      cmd_model.push_back(cmd_push_data);
      cmd_push_pend = 1'b0;
    end
    if (resp_pop_pend) begin
      void'(resp_model.pop_front());
      resp_pop_pend = 1'b0;
    end
    if (resp_push_pend) begin
      resp_model.push_back(resp_push_data);
      resp_push_pend = 1'b0;
    end
    cmd_rready_i  <= rready_nxt;
    resp_wvalid_i <= wvalid_nxt;
    resp_wdata_i  <= wdata_nxt;
    cycles++;
    if (cycles >= TimeoutCycles) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  initial begin
    apb_data_t word;
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    cmd_rready_i  = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i  = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    cmd_pop_en = 1'b1;
    for (int i = 0; i < NumCmdOps; i++) begin
      pop_mask = (i < NumCmdOps / 2) ? 15 : 3;  // Slow pops fill the queue, then drain
      apb_write(RegCmdPort, $random(seed));
      apb_write(RegCmdPort, $random(seed));
      apb_read(RegQueueStatus);
    end

    resp_push_en = 1'b1;
    pop_mask     = 1;
    for (int i = 0; i < NumRespOps; i++) begin
      push_mask = (i < NumRespOps / 2) ? 7 : 1;  // Sparse first, then dense
      apb_read(RegRespPort);
      apb_read(RegQueueStatus);
    end

    for (int i = 0; i < NumThldOps; i++) begin
      word = $random(seed);
      if (i % 2 == 0) begin
        word = word & 32'h0000_0f0f;
      end
      apb_write(RegThldCtrl, word);
      apb_read(RegThldCtrl);
      apb_write(RegCmdPort, $random(seed));
      apb_write(RegCmdPort, $random(seed));
      apb_read(RegRespPort);
      apb_read(RegQueueStatus);
      word = $random(seed);
      apb_write(apb_addr_t'(8'h14 + word[5:0]), word);  // Unmapped
      apb_read(apb_addr_t'(8'h14 + word[13:8]));
    end

    for (int i = 0; i < NumFlushOps; i++) begin
      flush_one();
    end

    if (i_hci_top.i_checker.fail_cnt != 0) begin
      abort_run("Protocol assertion in the bound checker failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule : tb_hci

/* testbench/hci_checker.sv */
// ----------------------------------------------------------
// HCI protocol checker: APB ready, reset state, command hold
// ----------------------------------------------------------
module hci_checker
  import hci_pkg::*;
(
  input logic clk_i,
  input logic rst_ni,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic cmd_rvalid_i,
  input logic cmd_rready_i,
  input cmd_t cmd_rdata_i,
  input logic cmd_flush_i,
  input logic resp_flush_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Assertion failures so far

  ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    psel_i && penable_i |-> pready_i)
    else begin
      $error("pready low during an APB access phase");
      fail_cnt++;
    end

  // First edge out of reset
  idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !cmd_rvalid_i && !cmd_flush_i && !resp_flush_i)
    else begin
      $error("command valid or flush bit high right after reset");
      fail_cnt++;
    end

  // A flush moves the head, so it is excluded
  cmd_head_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_rvalid_i && !cmd_rready_i && !cmd_flush_i |=> $stable(cmd_rdata_i))
    else begin
      $error("command head changed while stalled");
      fail_cnt++;
    end

endmodule : hci_checker

bind hci_top hci_checker i_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .cmd_rvalid_i(cmd_rvalid_o),
  .cmd_rready_i(cmd_rready_i),
  .cmd_rdata_i (cmd_rdata_o),
  .cmd_flush_i (cmd_flush),
  .resp_flush_i(resp_flush)
);

/* logic/hci_top.sv */
// ----------------------------------------------------------
// HCI queue top: APB register block with command and
// response queues toward the controller
// ----------------------------------------------------------
module hci_top
  import hci_pkg::*;
#(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8,
  localparam int unsigned CmdDepthW  = $clog2(CmdDepth + 1),
  localparam int unsigned RespDepthW = $clog2(RespDepth + 1)
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // APB slave
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  // Controller side
  output logic      cmd_rvalid_o,
  input  logic      cmd_rready_i,
  output cmd_t      cmd_rdata_o,
  input  logic      resp_wvalid_i,
  output logic      resp_wready_o,
  input  resp_t     resp_wdata_i,
  output logic      cmd_thld_trig_o,
  output logic      resp_thld_trig_o
);

  logic                  cmd_wvalid, cmd_wready;
  cmd_t                  cmd_wdata;
  logic [CmdDepthW-1:0]  cmd_depth;
  thld_t                 cmd_thld_raw, cmd_thld;
  logic                  cmd_flush, cmd_flush_done;

  logic                  resp_rvalid, resp_rready;
  resp_t                 resp_rdata;
  logic [RespDepthW-1:0] resp_depth;
  thld_t                 resp_thld_raw, resp_thld;
  logic                  resp_flush, resp_flush_done;

  hci_apb_regs #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) i_regs (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .cmd_wvalid_o     (cmd_wvalid),
    .cmd_wready_i     (cmd_wready),
    .cmd_wdata_o      (cmd_wdata),
    .cmd_depth_i      (cmd_depth),
    .cmd_thld_o       (cmd_thld_raw),
    .cmd_thld_i       (cmd_thld),
    .cmd_trig_i       (cmd_thld_trig_o),
    .cmd_flush_o      (cmd_flush),
    .cmd_flush_done_i (cmd_flush_done),
    .resp_rvalid_i    (resp_rvalid),
    .resp_rready_o    (resp_rready),
    .resp_rdata_i     (resp_rdata),
    .resp_depth_i     (resp_depth),
    .resp_thld_o      (resp_thld_raw),
    .resp_thld_i      (resp_thld),
    .resp_trig_i      (resp_thld_trig_o),
    .resp_flush_o     (resp_flush),
    .resp_flush_done_i(resp_flush_done)
  );

  // Trigger on free slots
  hci_queue #(
    .Depth    (CmdDepth),
    .payload_t(cmd_t),
    .FreeTrig (1'b1)
  ) i_cmd_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i    (cmd_wvalid),
    .wready_o    (cmd_wready),
    .wdata_i     (cmd_wdata),
    .rvalid_o    (cmd_rvalid_o),
    .rready_i    (cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .depth_o     (cmd_depth),
    .thld_i      (cmd_thld_raw),
    .thld_o      (cmd_thld),
    .trig_o      (cmd_thld_trig_o),
    .flush_i     (cmd_flush),
    .flush_done_o(cmd_flush_done)
  );

  // Trigger on filled entries
  hci_queue #(
    .Depth    (RespDepth),
    .payload_t(resp_t),
    .FreeTrig (1'b0)
  ) i_resp_queue (
    .clk_i,
    .rst_ni,
    .wvalid_i    (resp_wvalid_i),
    .wready_o    (resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .rvalid_o    (resp_rvalid),
    .rready_i    (resp_rready),
    .rdata_o     (resp_rdata),
    .depth_o     (resp_depth),
    .thld_i      (resp_thld_raw),
    .thld_o      (resp_thld),
    .trig_o      (resp_thld_trig_o),
    .flush_i     (resp_flush),
    .flush_done_o(resp_flush_done)
  );

endmodule : hci_top

/* logic/hci_apb_regs.sv */
// ----------------------------------------------------------
// HCI APB register block: reset control, thresholds,
// command and response ports, queue status
// ----------------------------------------------------------
module hci_apb_regs
  import hci_pkg::*;
#(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8,
  localparam int unsigned CmdDepthW  = $clog2(CmdDepth + 1),
  localparam int unsigned RespDepthW = $clog2(RespDepth + 1)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // APB slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  apb_addr_t             paddr_i,
  input  apb_data_t             pwdata_i,
  output apb_data_t             prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // Command queue
  output logic                  cmd_wvalid_o,
  input  logic                  cmd_wready_i,
  output cmd_t                  cmd_wdata_o,
  input  logic [CmdDepthW-1:0]  cmd_depth_i,
  output thld_t                 cmd_thld_o,
  input  thld_t                 cmd_thld_i,
  input  logic                  cmd_trig_i,
  output logic                  cmd_flush_o,
  input  logic                  cmd_flush_done_i,
  // Response queue
  input  logic                  resp_rvalid_i,
  output logic                  resp_rready_o,
  input  resp_t                 resp_rdata_i,
  input  logic [RespDepthW-1:0] resp_depth_i,
  output thld_t                 resp_thld_o,
  input  thld_t                 resp_thld_i,
  input  logic                  resp_trig_i,
  output logic                  resp_flush_o,
  input  logic                  resp_flush_done_i
);

  logic      acc, wr, rd;
  logic      sel_rst, sel_thld, sel_cmd, sel_resp, sel_stat, unmapped;
  logic      cmd_rst_q, resp_rst_q;
  logic      half_q;
  thld_t     cmd_thld_q, resp_thld_q;
  apb_data_t cmd_lo_q;

  assign acc = psel_i && penable_i;  // Access phase
  assign wr  = acc && pwrite_i;
  assign rd  = acc && !pwrite_i;

  assign sel_rst  = (paddr_i == RegResetCtrl);
  assign sel_thld = (paddr_i == RegThldCtrl);
  assign sel_cmd  = (paddr_i == RegCmdPort);
  assign sel_resp = (paddr_i == RegRespPort);
  assign sel_stat = (paddr_i == RegQueueStatus);
  assign unmapped = !(sel_rst || sel_thld || sel_cmd || sel_resp || sel_stat);

  assign pready_o = 1'b1;  // Zero-wait slave

  // Second dword completes the descriptor
  assign cmd_wvalid_o  = wr && sel_cmd && half_q;
  assign cmd_wdata_o   = {pwdata_i, cmd_lo_q};
  assign resp_rready_o = rd && sel_resp;  // Pop on read

  assign pslverr_o = acc && (unmapped
                             || (resp_rready_o && !resp_rvalid_i)
                             || (cmd_wvalid_o && !cmd_wready_i));

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;

  always_comb begin
    prdata_o = '0;
    if (rd) begin
      case (paddr_i)
        RegResetCtrl: prdata_o[1:0] = {resp_rst_q, cmd_rst_q};
        RegThldCtrl: prdata_o[2*ThldW-1:0] = {resp_thld_i, cmd_thld_i};  // Clipped values
        RegRespPort: begin
          if (resp_rvalid_i) begin
            prdata_o = resp_rdata_i;
          end
        end
        RegQueueStatus: begin
          prdata_o[7:0]  = 8'(cmd_depth_i);
          prdata_o[15:8] = 8'(resp_depth_i);
          prdata_o[16]   = cmd_trig_i;
          prdata_o[17]   = resp_trig_i;
        end
        default: prdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
      cmd_thld_q  <= thld_t'(1);
      resp_thld_q <= thld_t'(1);
      half_q      <= 1'b0;
    end else begin
      // Self-clearing once the queue has flushed
      if (cmd_flush_done_i) begin
        cmd_rst_q <= 1'b0;
      end
      if (resp_flush_done_i) begin
        resp_rst_q <= 1'b0;
      end
      if (wr && sel_rst) begin
        if (pwdata_i[0]) begin
          cmd_rst_q <= 1'b1;
        end
        if (pwdata_i[1]) begin
          resp_rst_q <= 1'b1;
        end
      end
      if (wr && sel_thld) begin
        cmd_thld_q  <= pwdata_i[ThldW-1:0];
        resp_thld_q <= pwdata_i[2*ThldW-1:ThldW];
      end
      if (wr && sel_cmd) begin
        half_q <= !half_q;  // A dropped command also ends the pair
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && sel_cmd && !half_q) begin
      cmd_lo_q <= pwdata_i;
    end
  end

endmodule : hci_apb_regs

/* logic/hci_queue.sv */
// ----------------------------------------------------------
// HCI queue: show-ahead FIFO with occupancy count, clipped
// ready threshold, threshold trigger and one-cycle flush
// ----------------------------------------------------------
module hci_queue
  import hci_pkg::*;
#(
  parameter int unsigned Depth     = 8,
  parameter type         payload_t = logic [31:0],
  parameter bit          FreeTrig  = 1'b0,
  localparam int unsigned PtrW   = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned DepthW = $clog2(Depth + 1)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Write side
  input  logic              wvalid_i,
  output logic              wready_o,
  input  payload_t          wdata_i,
  // Read side
  output logic              rvalid_o,
  input  logic              rready_i,
  output payload_t          rdata_o,
  // Status and control
  output logic [DepthW-1:0] depth_o,
  input  thld_t             thld_i,
  output thld_t             thld_o,
  output logic              trig_o,
  input  logic              flush_i,
  output logic              flush_done_o
);

  payload_t          mem_q [Depth];
  logic [PtrW-1:0]   wptr_q, rptr_q;
  logic [DepthW-1:0] count_q;
  logic [DepthW-1:0] free;
  logic              flush_done_q;
  logic              push, pop, do_flush;
  thld_t             eff_thld;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wready_o = (count_q != DepthW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];  // Head is always on the port
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;
  assign do_flush = flush_i && !flush_done_q;  // Once per request

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q       <= '0;
      rptr_q       <= '0;
      count_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= do_flush;
      if (do_flush) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (push) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (pop) begin
          rptr_q <= ptr_inc(rptr_q);
        end
        count_q <= count_q + DepthW'(push) - DepthW'(pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  assign depth_o      = count_q;
  assign flush_done_o = flush_done_q;

  // Threshold above the depth reads back as the depth
  assign thld_o   = (thld_i > thld_t'(Depth)) ? thld_t'(Depth) : thld_i;
  assign eff_thld = (thld_o == '0) ? thld_t'(1) : thld_o;
  assign free     = DepthW'(Depth) - count_q;
  assign trig_o   = FreeTrig ? (thld_t'(free) >= eff_thld)
                             : (thld_t'(count_q) >= eff_thld);

endmodule : hci_queue

/* logic/hci_pkg.sv */
// ----------------------------------------------------------
// I3C HCI queue package
// APB widths, register map and queue payload types
// ----------------------------------------------------------
package hci_pkg;

  localparam int unsigned ApbAw = 8;
  localparam int unsigned ApbDw = 32;
  localparam int unsigned ThldW = 8;

  typedef logic [ApbAw-1:0] apb_addr_t;
  typedef logic [ApbDw-1:0] apb_data_t;
  typedef logic [ThldW-1:0] thld_t;

  // Low dword arrives with the first port write
  typedef logic [2*ApbDw-1:0] cmd_t;
  typedef logic [ApbDw-1:0] resp_t;

  // Register map
  localparam apb_addr_t RegResetCtrl   = 8'h00;
  localparam apb_addr_t RegThldCtrl    = 8'h04;
  localparam apb_addr_t RegCmdPort     = 8'h08;
  localparam apb_addr_t RegRespPort    = 8'h0C;
  localparam apb_addr_t RegQueueStatus = 8'h10;

endpackage : hci_pkg
